// File: src.f
+incdir+dv
source/cache_geometry_pkg.sv
source/cache_message_pkg.sv
source/cache_port_if.sv
source/cache_fill_stage.sv
source/cache_arrays.sv
source/cache_lookup_pipeline.sv
source/cache_response_builder.sv
source/vertex_cache_top.sv
dv/vertex_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the vertex cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module vertex_cache_tb -f src.f -o vertex_cache_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/vertex_cache_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
	echo "Testbench reported failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
exit 0

// File: dv/vertex_cache_tb_checks.svh
//////////////////////////////////////////////////////////////////////
// Reference model of the cache contents and read predictor
// Galois LFSR step and typed compare tasks
//////////////////////////////////////////////////////////////////////

`ifndef VERTEX_CACHE_TB_CHECKS_SVH
`define VERTEX_CACHE_TB_CHECKS_SVH

// One expected output event
typedef struct packed {
	logic [2:0]                                    test_id;
	logic [cache_message_pkg::DATA_LINE_BITS-1:0]  line;
	logic [cache_message_pkg::CMD_TAG_BITS-1:0]    tag;
	logic [cache_geometry_pkg::VERTEX_ID_BITS-1:0] address;
	int                                            due;
} expect_t;

// Model of what the arrays should hold
logic [cache_geometry_pkg::CACHE_TAG_BITS-1:0] model_tag [cache_geometry_pkg::CACHE_ENTRIES];
logic [cache_message_pkg::EDGE_DATA_BITS-1:0]  model_data [cache_geometry_pkg::CACHE_ENTRIES];
logic                                          model_valid [cache_geometry_pkg::CACHE_ENTRIES];

// Right-shift Galois form, taps of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	if (state[0]) begin
		return (state >> 1) ^ 32'h80200003;
	end
	return state >> 1;
endfunction

task automatic clear_model();
	for (int i = 0; i < cache_geometry_pkg::CACHE_ENTRIES; i++) begin
		model_valid[i] = 1'b0;
	end
endtask

task automatic model_fill(input logic [31:0] id, input logic [31:0] data);
	cache_geometry_pkg::vertex_address_u split;
	split.vertex_id = id;
	model_tag[split.fields.index]   = split.fields.tag;
	model_data[split.fields.index]  = data;
	model_valid[split.fields.index] = 1'b1;
endtask

// Returns the hit decision, line holds the expected copies
function automatic logic predict_read(input logic [31:0] address,
	output logic [cache_message_pkg::DATA_LINE_BITS-1:0] line);
	cache_geometry_pkg::vertex_address_u        split;
	logic [cache_geometry_pkg::CACHE_INDEX_BITS-1:0] index;
	split.vertex_id = address;
	index = split.fields.index;
	for (int w = 0; w < cache_message_pkg::DATA_LINE_WORDS; w++) begin
		line[w*cache_message_pkg::EDGE_DATA_BITS +: cache_message_pkg::EDGE_DATA_BITS] =
			model_data[index];
	end
	return model_valid[index] && (model_tag[index] == split.fields.tag);
endfunction

function automatic string test_name(input logic [2:0] test_id);
	case (test_id)
		3'd1:    return "reset_miss";
		3'd2:    return "fill_hit";
		3'd3:    return "conflict";
		default: return "back_to_back";
	endcase
endfunction

task automatic check_data_line(input string name,
	input logic [cache_message_pkg::DATA_LINE_BITS-1:0] expected,
	input logic [cache_message_pkg::DATA_LINE_BITS-1:0] actual);
	if (actual !== expected) begin
		$display("Fail %s: expected %h, actual %h", name, expected, actual);
		$display("Simulation FAILED");
		$fatal(1);
	end
endtask

task automatic check_cmd_tag(input string name,
	input logic [cache_message_pkg::CMD_TAG_BITS-1:0] expected,
	input logic [cache_message_pkg::CMD_TAG_BITS-1:0] actual);
	if (actual !== expected) begin
		$display("Fail %s: expected %h, actual %h", name, expected, actual);
		$display("Simulation FAILED");
		$fatal(1);
	end
endtask

task automatic check_address(input string name,
	input logic [cache_geometry_pkg::VERTEX_ID_BITS-1:0] expected,
	input logic [cache_geometry_pkg::VERTEX_ID_BITS-1:0] actual);
	if (actual !== expected) begin
		$display("Fail %s: expected %h, actual %h", name, expected, actual);
		$display("Simulation FAILED");
		$fatal(1);
	end
endtask

// Arrival cycle of an output event
task automatic check_cycle(input string name, input int expected, input int actual);
	if (actual != expected) begin
		$display("Fail %s: expected cycle %0d, actual cycle %0d", name, expected, actual);
		$display("Simulation FAILED");
		$fatal(1);
	end
endtask

task automatic check_pending(input int pending, input string what);
	if (pending == 0) begin
		$display("Unexpected output: %s", what);
		$display("Simulation FAILED");
		$fatal(1);
	end
endtask

`endif

// File: dv/vertex_cache_tb.sv
//////////////////////////////////////////////////////////////////////
// Vertex cache testbench
// Clock, reset, stimulus, timeout and output comparison
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vertex_cache_tb;

	localparam int RSP_DELAY = 4;

	// Test lengths in cycles
	localparam int RESET_CYCLES = 16;
	localparam int QUIET_CYCLES = 8;
	localparam int COLD_READS   = 4;
	localparam int HIT_PAIRS    = 6;
	localparam int BURST_FILLS  = 16;
	localparam int BURST_READS  = 48;
	localparam int STIM_CYCLES  = RESET_CYCLES + QUIET_CYCLES + COLD_READS + HIT_PAIRS * 4 + 6 +
		BURST_FILLS + 2 + BURST_READS;
	localparam int TIMEOUT_CYCLES = STIM_CYCLES + 3 + RSP_DELAY + 20;

	logic                                          clock;
	logic                                          rstn_internal;
	logic                                          fill_valid;
	logic [cache_geometry_pkg::VERTEX_ID_BITS-1:0] fill_vertex_id;
	logic [cache_message_pkg::EDGE_DATA_BITS-1:0]  fill_data;
	logic                                          read_valid;
	logic [cache_geometry_pkg::VERTEX_ID_BITS-1:0] read_address;
	logic [cache_message_pkg::CMD_TAG_BITS-1:0]    read_cmd_tag;
	logic                                          data_valid;
	logic [cache_message_pkg::DATA_LINE_BITS-1:0]  data_line;
	logic [cache_message_pkg::CMD_TAG_BITS-1:0]    data_cmd_tag;
	logic                                          response_valid;
	logic [cache_message_pkg::CMD_TAG_BITS-1:0]    response_cmd_tag;
	logic                                          miss_valid;
	logic [cache_geometry_pkg::VERTEX_ID_BITS-1:0] miss_address;
	logic [cache_message_pkg::CMD_TAG_BITS-1:0]    miss_cmd_tag;

	int          cycle_count;
	logic [31:0] lfsr_state;
	logic [31:0] burst_ids [BURST_FILLS];

	`include "vertex_cache_tb_checks.svh"

	// Expected events, oldest first
	expect_t data_q [$];
	expect_t response_q [$];
	expect_t miss_q [$];
	expect_t head;

	vertex_cache_top #(
		.RSP_DELAY (RSP_DELAY)
	) i_dut (
		.clock            (clock),
		.rstn_internal    (rstn_internal),
		.fill_valid       (fill_valid),
		.fill_vertex_id   (fill_vertex_id),
		.fill_data        (fill_data),
		.read_valid       (read_valid),
		.read_address     (read_address),
		.read_cmd_tag     (read_cmd_tag),
		.data_valid       (data_valid),
		.data_line        (data_line),
		.data_cmd_tag     (data_cmd_tag),
		.response_valid   (response_valid),
		.response_cmd_tag (response_cmd_tag),
		.miss_valid       (miss_valid),
		.miss_address     (miss_address),
		.miss_cmd_tag     (miss_cmd_tag)
	);

	always #50 clock = ~clock;

	// Cycle count and run limit
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$fatal(1);
		end
	end

	// One LFSR step per bit taken
	task automatic draw_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int b = 0; b < count; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			fill_valid <= 1'b0;
			read_valid <= 1'b0;
		end
	endtask

	task automatic issue_fill(input logic [31:0] id, input logic [31:0] data);
		@(posedge clock);
		fill_valid     <= 1'b1;
		fill_vertex_id <= id;
		fill_data      <= data;
		read_valid     <= 1'b0;
		model_fill(id, data);
	endtask

	// Read plus its predicted outcome, sampled one edge later
	task automatic issue_read(input logic [2:0] test_id, input logic [31:0] address);
		logic [31:0]                                  tag_bits;
		logic [cache_message_pkg::DATA_LINE_BITS-1:0] line;
		expect_t                                      e;
		draw_bits(8, tag_bits);
		@(posedge clock);
		read_valid   <= 1'b1;
		read_address <= address;
		read_cmd_tag <= tag_bits[7:0];
		fill_valid   <= 1'b0;
		e.test_id = test_id;
		e.tag     = tag_bits[7:0];
		e.address = address;
		if (predict_read(address, line)) begin
			e.line = line;
			e.due  = cycle_count + 5;
			data_q.push_back(e);
		end else begin
			e.line = '0;
			e.due  = cycle_count + 4;
			miss_q.push_back(e);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Comparison, outputs sampled mid cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (data_valid) begin
			check_pending(data_q.size(), "data_valid with no hit outstanding");
			head = data_q.pop_front();
			check_cycle({test_name(head.test_id), " data_valid"}, head.due, cycle_count);
			check_data_line({test_name(head.test_id), " data_line"}, head.line, data_line);
			check_cmd_tag({test_name(head.test_id), " data_cmd_tag"}, head.tag, data_cmd_tag);
			// Response due a fixed delay after the line
			head.due = cycle_count + RSP_DELAY;
			response_q.push_back(head);
		end
		if (response_valid) begin
			check_pending(response_q.size(), "response_valid with no data line before it");
			head = response_q.pop_front();
			check_cycle({test_name(head.test_id), " response_valid"}, head.due, cycle_count);
			check_cmd_tag({test_name(head.test_id), " response_cmd_tag"}, head.tag,
				response_cmd_tag);
		end
		if (miss_valid) begin
			check_pending(miss_q.size(), "miss_valid with no miss outstanding");
			head = miss_q.pop_front();
			check_cycle({test_name(head.test_id), " miss_valid"}, head.due, cycle_count);
			check_address({test_name(head.test_id), " miss_address"}, head.address, miss_address);
			check_cmd_tag({test_name(head.test_id), " miss_cmd_tag"}, head.tag, miss_cmd_tag);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] id;
		logic [31:0] data;
		logic [31:0] pick;
		clock          = 1'b0;
		rstn_internal  = 1'b0;
		fill_valid     = 1'b0;
		fill_vertex_id = '0;
		fill_data      = '0;
		read_valid     = 1'b0;
		read_address   = '0;
		read_cmd_tag   = '0;
		cycle_count    = 0;
		lfsr_state     = 32'h41f42b19;
		clear_model();
		repeat (RESET_CYCLES) @(posedge clock);
		rstn_internal <= 1'b1;

		// Quiet outputs, then cold reads that all miss
		idle(QUIET_CYCLES);
		repeat (COLD_READS) begin
			draw_bits(32, id);
			issue_read(3'd1, id);
		end

		// Fill then read back the same id
		repeat (HIT_PAIRS) begin
			draw_bits(32, id);
			draw_bits(32, data);
			issue_fill(id, data);
			idle(2);
			issue_read(3'd2, id);
		end

		// Same index, tag differs in bit 6 at least
		draw_bits(32, id);
		draw_bits(32, data);
		issue_fill(id, data);
		draw_bits(32, pick);
		pick = id ^ {pick[31:7], 1'b1, 6'b0};
		draw_bits(32, data);
		issue_fill(pick, data);
		idle(2);
		issue_read(3'd3, id);
		issue_read(3'd3, pick);

		// Random fills, then a read every cycle
		for (int i = 0; i < BURST_FILLS; i++) begin
			draw_bits(32, id);
			draw_bits(32, data);
			burst_ids[i] = id;
			issue_fill(id, data);
		end
		idle(2);
		repeat (BURST_READS) begin
			draw_bits(1, pick);
			if (pick[0]) begin
				draw_bits(4, pick);
				id = burst_ids[pick[3:0]];
			end else begin
				draw_bits(32, id);
			end
			issue_read(3'd4, id);
		end

		// Drain the pipeline and the response delay
		idle(3 + RSP_DELAY + 2);
		if (data_q.size() + response_q.size() + miss_q.size() != 0) begin
			$display("Run ended with %0d data, %0d response and %0d miss events never seen",
				data_q.size(), response_q.size(), miss_q.size());
			$display("Simulation FAILED");
			$fatal(1);
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

// File: source/vertex_cache_top.sv
//////////////////////////////////////////////////////////////////////
// Vertex cache top level
// Fill stage, arrays, lookup pipeline and response builder
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vertex_cache_top #(
	parameter int RSP_DELAY = 4
) (
	input  logic                                          clock,
	input  logic                                          rstn_internal,
	input  logic                                          fill_valid,
	input  logic [cache_geometry_pkg::VERTEX_ID_BITS-1:0] fill_vertex_id,
	input  logic [cache_message_pkg::EDGE_DATA_BITS-1:0]  fill_data,
	input  logic                                          read_valid,
	input  logic [cache_geometry_pkg::VERTEX_ID_BITS-1:0] read_address,
	input  logic [cache_message_pkg::CMD_TAG_BITS-1:0]    read_cmd_tag,
	output logic                                          data_valid,
	output logic [cache_message_pkg::DATA_LINE_BITS-1:0]  data_line,
	output logic [cache_message_pkg::CMD_TAG_BITS-1:0]    data_cmd_tag,
	output logic                                          response_valid,
	output logic [cache_message_pkg::CMD_TAG_BITS-1:0]    response_cmd_tag,
	output logic                                          miss_valid,
	output logic [cache_geometry_pkg::VERTEX_ID_BITS-1:0] miss_address,
	output logic [cache_message_pkg::CMD_TAG_BITS-1:0]    miss_cmd_tag
);

	// Hit path from lookup to response builder
	logic                                        hit_valid;
	logic [cache_message_pkg::EDGE_DATA_BITS-1:0] hit_data;
	logic [cache_message_pkg::CMD_TAG_BITS-1:0]   hit_cmd_tag;

	cache_port_if cache_port ();

	cache_fill_stage i_fill_stage (
		.clock          (clock),
		.rstn_internal  (rstn_internal),
		.fill_valid     (fill_valid),
		.fill_vertex_id (fill_vertex_id),
		.fill_data      (fill_data),
		.port           (cache_port.fill)
	);

	cache_arrays i_arrays (
		.clock         (clock),
		.rstn_internal (rstn_internal),
		.port          (cache_port.memory)
	);

	cache_lookup_pipeline i_lookup (
		.clock         (clock),
		.rstn_internal (rstn_internal),
		.read_valid    (read_valid),
		.read_address  (read_address),
		.read_cmd_tag  (read_cmd_tag),
		.port          (cache_port.lookup),
		.hit_valid     (hit_valid),
		.hit_data      (hit_data),
		.hit_cmd_tag   (hit_cmd_tag),
		.miss_valid    (miss_valid),
		.miss_address  (miss_address),
		.miss_cmd_tag  (miss_cmd_tag)
	);

	cache_response_builder #(
		.RSP_DELAY (RSP_DELAY)
	) i_response (
		.clock            (clock),
		.rstn_internal    (rstn_internal),
		.hit_valid        (hit_valid),
		.hit_data         (hit_data),
		.hit_cmd_tag      (hit_cmd_tag),
		.data_valid       (data_valid),
		.data_line        (data_line),
		.data_cmd_tag     (data_cmd_tag),
		.response_valid   (response_valid),
		.response_cmd_tag (response_cmd_tag)
	);

endmodule

// File: source/cache_response_builder.sv
//////////////////////////////////////////////////////////////////////
// Data line builder and delayed completion response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cache_response_builder #(
	parameter int RSP_DELAY = 4
) (
	input  logic                                         clock,
	input  logic                                         rstn_internal,
	input  logic                                         hit_valid,
	input  logic [cache_message_pkg::EDGE_DATA_BITS-1:0] hit_data,
	input  logic [cache_message_pkg::CMD_TAG_BITS-1:0]   hit_cmd_tag,
	output logic                                         data_valid,
	output logic [cache_message_pkg::DATA_LINE_BITS-1:0] data_line,
	output logic [cache_message_pkg::CMD_TAG_BITS-1:0]  data_cmd_tag,
	output logic                                         response_valid,
	output logic [cache_message_pkg::CMD_TAG_BITS-1:0]  response_cmd_tag
);

	// Delay line whose last stage drives the response
	logic [RSP_DELAY-1:0]                                        rsp_valid_pipe;
	logic [RSP_DELAY-1:0][cache_message_pkg::CMD_TAG_BITS-1:0] rsp_tag_pipe;

	//////////////////////////////////////////////////////////////////////
	// Data line
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			data_valid <= 1'b0;
		end else begin
			data_valid <= hit_valid;
		end
	end

	// Every word of the line carries the hit word
	always_ff @(posedge clock) begin
		data_line    <= {cache_message_pkg::DATA_LINE_WORDS{hit_data}};
		data_cmd_tag <= hit_cmd_tag;
	end

	//////////////////////////////////////////////////////////////////////
	// Response delay
	//////////////////////////////////////////////////////////////////////

	// Stage 0 takes the data line strobe, each later stage its neighbour
	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			rsp_valid_pipe <= '0;
		end else begin
			rsp_valid_pipe[0] <= data_valid;
			for (int i = 1; i < RSP_DELAY; i++) begin
				rsp_valid_pipe[i] <= rsp_valid_pipe[i-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		rsp_tag_pipe[0] <= data_cmd_tag;
		for (int i = 1; i < RSP_DELAY; i++) begin
			rsp_tag_pipe[i] <= rsp_tag_pipe[i-1];
		end
	end

	assign response_valid   = rsp_valid_pipe[RSP_DELAY-1];
	assign response_cmd_tag = rsp_tag_pipe[RSP_DELAY-1];

	// Response trails its data line by RSP_DELAY cycles with the same tag
	response_follows_data: assert property (
		@(posedge clock) disable iff (!rstn_internal)
		response_valid |-> ($past(data_valid, RSP_DELAY) &&
			response_cmd_tag == $past(data_cmd_tag, RSP_DELAY))
	);

endmodule

// File: source/cache_lookup_pipeline.sv
//////////////////////////////////////////////////////////////////////
// Read lookup pipeline
// Address split, array read, tag compare and hit or miss decision
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cache_lookup_pipeline (
	input  logic                                          clock,
	input  logic                                          rstn_internal,
	input  logic                                          read_valid,
	input  logic [cache_geometry_pkg::VERTEX_ID_BITS-1:0] read_address,
	input  logic [cache_message_pkg::CMD_TAG_BITS-1:0]    read_cmd_tag,
	cache_port_if.lookup                                  port,
	output logic                                          hit_valid,
	output logic [cache_message_pkg::EDGE_DATA_BITS-1:0]  hit_data,
	output logic [cache_message_pkg::CMD_TAG_BITS-1:0]    hit_cmd_tag,
	output logic                                          miss_valid,
	output logic [cache_geometry_pkg::VERTEX_ID_BITS-1:0] miss_address,
	output logic [cache_message_pkg::CMD_TAG_BITS-1:0]    miss_cmd_tag
);

	// Stage one, command as sampled
	logic                                       s1_valid;
	cache_geometry_pkg::vertex_address_u        s1_address;
	logic [cache_message_pkg::CMD_TAG_BITS-1:0] s1_cmd_tag;

	// Stage two, aligned with the array read data
	logic                                       s2_valid;
	cache_geometry_pkg::vertex_address_u        s2_address;
	logic [cache_message_pkg::CMD_TAG_BITS-1:0] s2_cmd_tag;

	logic lookup_hit;

	// Array is addressed straight from stage one
	assign port.read_index = s1_address.fields.index;

	//////////////////////////////////////////////////////////////////////
	// Command stages
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= read_valid;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clock) begin
		s1_address.vertex_id <= read_address;
		s1_cmd_tag           <= read_cmd_tag;
		s2_address           <= s1_address;
		s2_cmd_tag           <= s1_cmd_tag;
	end

	// Hit needs a written slot holding the same tag
	assign lookup_hit = s2_valid && port.read_entry_valid &&
		(port.read_tag == s2_address.fields.tag);

	//////////////////////////////////////////////////////////////////////
	// Result register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			hit_valid  <= 1'b0;
			miss_valid <= 1'b0;
		end else begin
			hit_valid  <= lookup_hit;
			miss_valid <= s2_valid && !lookup_hit;
		end
	end

	// Miss goes out unchanged for memory to serve
	always_ff @(posedge clock) begin
		hit_data     <= port.read_data;
		hit_cmd_tag  <= s2_cmd_tag;
		miss_address <= s2_address.vertex_id;
		miss_cmd_tag <= s2_cmd_tag;
	end

	hit_miss_exclusive: assert property (
		@(posedge clock) disable iff (!rstn_internal)
		!(hit_valid && miss_valid)
	);

endmodule

// File: source/cache_arrays.sv
//////////////////////////////////////////////////////////////////////
// Tag, valid and data storage of the vertex cache
// One write port, one registered read port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cache_arrays (
	input  logic          clock,
	input  logic          rstn_internal,
	cache_port_if.memory  port
);

	// Storage arrays, one slot per index
	logic [cache_geometry_pkg::CACHE_TAG_BITS-1:0] tag_array [cache_geometry_pkg::CACHE_ENTRIES];
	logic [cache_message_pkg::EDGE_DATA_BITS-1:0]  data_array [cache_geometry_pkg::CACHE_ENTRIES];

	// Entry valid bits, cleared so unwritten slots miss
	logic [cache_geometry_pkg::CACHE_ENTRIES-1:0] valid_bits;

	//////////////////////////////////////////////////////////////////////
	// Valid bits and registered valid read
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			valid_bits            <= '0;
			port.read_entry_valid <= 1'b0;
		end else begin
			// Old value is read when the same slot is written now
			port.read_entry_valid <= valid_bits[port.read_index];
			if (port.write_enable) begin
				valid_bits[port.write_index] <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Tag and data arrays
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		port.read_tag  <= tag_array[port.read_index];
		port.read_data <= data_array[port.read_index];
		if (port.write_enable) begin
			tag_array[port.write_index]  <= port.write_tag;
			data_array[port.write_index] <= port.write_data;
		end
	end

endmodule

// File: source/cache_fill_stage.sv
//////////////////////////////////////////////////////////////////////
// Fill request register stage
// Splits the vertex id into index and tag for the array write port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cache_fill_stage (
	input  logic                                        clock,
	input  logic                                        rstn_internal,
	input  logic                                        fill_valid,
	input  logic [cache_geometry_pkg::VERTEX_ID_BITS-1:0] fill_vertex_id,
	input  logic [cache_message_pkg::EDGE_DATA_BITS-1:0]  fill_data,
	cache_port_if.fill                                  port
);

	// Incoming id seen through the tag/index view
	cache_geometry_pkg::vertex_address_u fill_address;

	assign fill_address.vertex_id = fill_vertex_id;

	// Write strobe, one pulse per fill
	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			port.write_enable <= 1'b0;
		end else begin
			port.write_enable <= fill_valid;
		end
	end

	// Write payload, only meaningful with the strobe
	always_ff @(posedge clock) begin
		port.write_index <= fill_address.fields.index;
		port.write_tag   <= fill_address.fields.tag;
		port.write_data  <= fill_data;
	end

	// Arrays must never see a write to an unknown slot
	write_index_known: assert property (
		@(posedge clock) disable iff (!rstn_internal)
		port.write_enable |-> !$isunknown(port.write_index)
	);

endmodule

// File: source/cache_port_if.sv
//////////////////////////////////////////////////////////////////////
// Storage port between fill stage, lookup pipeline and cache arrays
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface cache_port_if;

	// Write side, driven by the fill stage
	logic                                       write_enable;
	logic [cache_geometry_pkg::CACHE_INDEX_BITS-1:0] write_index;
	logic [cache_geometry_pkg::CACHE_TAG_BITS-1:0]   write_tag;
	logic [cache_message_pkg::EDGE_DATA_BITS-1:0]    write_data;

	// Read side, index in and registered entry out
	logic [cache_geometry_pkg::CACHE_INDEX_BITS-1:0] read_index;
	logic [cache_geometry_pkg::CACHE_TAG_BITS-1:0]   read_tag;
	logic                                       read_entry_valid;
	logic [cache_message_pkg::EDGE_DATA_BITS-1:0]    read_data;

	modport fill (output write_enable, write_index, write_tag, write_data);

	modport lookup (output read_index, input read_tag, read_entry_valid, read_data);

	// Storage side sees everything the other two drive
	modport memory (
		input  write_enable, write_index, write_tag, write_data, read_index,
		output read_tag, read_entry_valid, read_data
	);

endinterface

// File: source/cache_message_pkg.sv
//////////////////////////////////////////////////////////////////////
// Widths of command tags, edge data words and returned data lines
//////////////////////////////////////////////////////////////////////

package cache_message_pkg;

	// Edge data word stored per entry
	parameter int EDGE_DATA_BITS = 32;

	// Returned line holds several copies of the stored word
	parameter int DATA_LINE_WORDS = 4;
	parameter int DATA_LINE_BITS  = DATA_LINE_WORDS * EDGE_DATA_BITS;

	// Command tag follows a read through to its data and response
	parameter int CMD_TAG_BITS = 8;

endpackage

// File: source/cache_geometry_pkg.sv
//////////////////////////////////////////////////////////////////////
// Cache geometry constants for the direct-mapped vertex cache
// Vertex address union with flat id and tag/index views
//////////////////////////////////////////////////////////////////////

package cache_geometry_pkg;

	// One vertex id is one 32-bit word
	parameter int VERTEX_ID_BITS = 32;

	// 64 entries, direct mapped on the low id bits
	parameter int CACHE_INDEX_BITS = 6;
	parameter int CACHE_ENTRIES    = 1 << CACHE_INDEX_BITS;

	// Everything above the index is kept as tag
	parameter int CACHE_TAG_BITS = VERTEX_ID_BITS - CACHE_INDEX_BITS;

	// Same word, seen flat or split into tag and index
	typedef union packed {
		logic [VERTEX_ID_BITS-1:0] vertex_id;
		struct packed {
			logic [CACHE_TAG_BITS-1:0]   tag;
			logic [CACHE_INDEX_BITS-1:0] index;
		} fields;
	} vertex_address_u;

endpackage
